/* hw/scan_settings.svh */
`ifndef SCAN_SETTINGS_SVH
`define SCAN_SETTINGS_SVH

// Sizing of the content scanner

// Number of interleaved flows with their own saved state
`define SCAN_NUM_FLOWS 64

// Flow identifier width, enough to address every flow
`define SCAN_FLOW_W 6

// Matching packet counter width, counter wraps
`define SCAN_COUNT_W 16

// Automaton state word as stored per flow
// Wider than the five states of the hard-coded signature needs
`define SCAN_STATE_W 11

`endif

/* hw/scan_pkg.sv */
`default_nettype none

`include "scan_settings.svh"

// Types of the packet stream side of the scanner
package scan_pkg;

   // One payload character, one per byte strobe
   typedef logic [7:0] byte_t;

   // Flow identifier, held with load_state and with eop
   typedef logic [`SCAN_FLOW_W-1:0] flow_id_t;

   // Number of matching enabled packets
   typedef logic [`SCAN_COUNT_W-1:0] match_count_t;

endpackage

`default_nettype wire

/* hw/dfa_pkg.sv */
`default_nettype none

`include "scan_settings.svh"

// Types and encodings of the signature automaton
package dfa_pkg;

   // Automaton state word, also the width of each saved flow entry
   typedef logic [`SCAN_STATE_W-1:0] dfa_state_t;

   // Nothing of the signature seen
   localparam dfa_state_t DFA_IDLE = 'd0;
   // "e" seen
   localparam dfa_state_t DFA_E    = 'd1;
   // "ev" seen
   localparam dfa_state_t DFA_EV   = 'd2;
   // "evi" seen
   localparam dfa_state_t DFA_EVI  = 'd3;
   // "evil" just completed
   localparam dfa_state_t DFA_HIT  = 'd4;

   // Signature characters in ASCII
   localparam logic [7:0] SIG_E = 8'h65;
   localparam logic [7:0] SIG_V = 8'h76;
   localparam logic [7:0] SIG_I = 8'h69;
   localparam logic [7:0] SIG_L = 8'h6c;

endpackage

`default_nettype wire

/* hw/stream_context.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_settings.svh"

// Stage 1, restores the automaton state of a flow at packet start
module stream_context import scan_pkg::*, dfa_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       load_state,
   input  logic       new_stream_id,
   input  flow_id_t   stream_id,
   input  byte_t      char_in,
   input  logic       char_in_vld,
   input  logic       eop,
   input  logic       enable,
   input  logic       save_vld,
   input  flow_id_t   save_flow,
   input  dfa_state_t save_state,
   output dfa_state_t ctx_state,
   output logic       ctx_state_vld,
   output byte_t      ctx_char,
   output logic       ctx_char_vld,
   output logic       ctx_eop,
   output logic       ctx_enable,
   output flow_id_t   ctx_flow,
   output logic       ctx_start
);

   // One saved automaton state per flow
   dfa_state_t state_mem [`SCAN_NUM_FLOWS];

   // Enabled eop one stage behind ctx_eop
   logic     pend_vld;
   flow_id_t pend_flow;

   // Save for the restored flow is on the write-back port now
   logic fwd_hit;
   // Save for the restored flow is issued but not yet on the write-back port
   logic keep_hit;

   assign fwd_hit = save_vld && (save_flow == stream_id);

   // Packet ended one or two cycles ago on this flow with enable
   // The automaton register still holds exactly the state about to be saved
   assign keep_hit = (ctx_eop && ctx_enable && (ctx_flow == stream_id)) ||
                     (pend_vld && (pend_flow == stream_id));

   // Write-back from stage 3
   always_ff @(posedge clk)
   begin
      if (save_vld)
         state_mem[save_flow] <= save_state;
   end

   // Restore word, fresh flows start from the idle state
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream_id)
            ctx_state <= DFA_IDLE;
         else if (fwd_hit)
            ctx_state <= save_state;
         else
            ctx_state <= state_mem[stream_id];
      end
   end

   // Strobes, delayed one cycle to line up with the restored state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ctx_state_vld <= 1'b0;
         ctx_char_vld  <= 1'b0;
         ctx_eop       <= 1'b0;
         ctx_start     <= 1'b0;
         pend_vld      <= 1'b0;
      end
      else
      begin
         // No load when the automaton already holds the flow's state
         ctx_state_vld <= load_state && (new_stream_id || !keep_hit);
         ctx_char_vld  <= char_in_vld;
         ctx_eop       <= eop;
         ctx_start     <= load_state;
         pend_vld      <= ctx_eop && ctx_enable;
      end
   end

   // Payload follows the strobes
   always_ff @(posedge clk)
   begin
      ctx_char   <= char_in;
      ctx_enable <= enable;
      ctx_flow   <= stream_id;
      pend_flow  <= ctx_flow;
   end

endmodule

`default_nettype wire

/* hw/regex_dfa.sv */
`timescale 1ns/1ps
`default_nettype none

// Stage 2, steps the "evil" automaton one byte per cycle
module regex_dfa import scan_pkg::*, dfa_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  dfa_state_t ctx_state,
   input  logic       ctx_state_vld,
   input  byte_t      ctx_char,
   input  logic       ctx_char_vld,
   input  logic       ctx_eop,
   input  logic       ctx_enable,
   input  flow_id_t   ctx_flow,
   input  logic       ctx_start,
   output dfa_state_t dfa_state,
   output logic       dfa_accept,
   output logic       dfa_eop,
   output logic       dfa_enable,
   output flow_id_t   dfa_flow,
   output logic       dfa_start
);

   // Transition function from the prefix rule of the signature
   function automatic dfa_state_t step(input dfa_state_t cur, input byte_t ch);
      dfa_state_t nxt;
      // An "e" always restarts a partial match
      if (ch == SIG_E)
         nxt = DFA_E;
      else
      begin
         case (cur)
            DFA_E:
               nxt = (ch == SIG_V) ? DFA_EV : DFA_IDLE;
            DFA_EV:
               nxt = (ch == SIG_I) ? DFA_EVI : DFA_IDLE;
            DFA_EVI:
               nxt = (ch == SIG_L) ? DFA_HIT : DFA_IDLE;
            // Idle, hit and unused codes search from scratch
            default:
               nxt = DFA_IDLE;
         endcase
      end
      return nxt;
   endfunction

   // State the byte applies to
   dfa_state_t cur_state;
   // State after this cycle's byte, if any
   dfa_state_t next_state;

   always_comb
   begin
      // A restored state takes over from the running one
      cur_state  = ctx_state_vld ? ctx_state : dfa_state;
      next_state = ctx_char_vld ? step(cur_state, ctx_char) : cur_state;
   end

   // Automaton register and strobes
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         dfa_state  <= DFA_IDLE;
         dfa_accept <= 1'b0;
         dfa_eop    <= 1'b0;
         dfa_start  <= 1'b0;
      end
      else
      begin
         dfa_state  <= next_state;
         // Pulse only on the byte that enters the hit state
         dfa_accept <= ctx_char_vld && (next_state == DFA_HIT);
         dfa_eop    <= ctx_eop;
         dfa_start  <= ctx_start;
      end
   end

   // End of packet payload, one register of delay
   always_ff @(posedge clk)
   begin
      dfa_enable <= ctx_enable;
      dfa_flow   <= ctx_flow;
   end

endmodule

`default_nettype wire

/* hw/match_tally.sv */
`timescale 1ns/1ps
`default_nettype none

// Stage 3, per-packet match accounting and state write-back
module match_tally import scan_pkg::*, dfa_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  dfa_state_t   dfa_state,
   input  logic         dfa_accept,
   input  logic         dfa_eop,
   input  logic         dfa_enable,
   input  flow_id_t     dfa_flow,
   input  logic         dfa_start,
   output match_count_t count,
   output logic         fired,
   output logic         save_vld,
   output flow_id_t     save_flow,
   output dfa_state_t   save_state
);

   // Current packet has matched at least once
   logic pkt_match;

   assign fired = pkt_match;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pkt_match <= 1'b0;
         count     <= '0;
         save_vld  <= 1'b0;
      end
      else
      begin
         // Only enabled packets hand their state back
         save_vld <= dfa_eop && dfa_enable;

         // Fresh flag for every packet
         if (dfa_start)
            pkt_match <= 1'b0;

         // Several hits in one packet still set one flag
         if (dfa_accept)
            pkt_match <= 1'b1;

         if (dfa_eop)
         begin
            if (dfa_enable)
               count <= count + match_count_t'(pkt_match);
            else
               // Disabled packet, forget the match
               pkt_match <= 1'b0;
         end
      end
   end

   // Final state of the packet, written into the flow memory
   always_ff @(posedge clk)
   begin
      if (dfa_eop)
      begin
         save_flow  <= dfa_flow;
         save_state <= dfa_state;
      end
   end

endmodule

`default_nettype wire

/* hw/regex_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

// Multi-flow signature scanner, three-stage pipeline
module regex_scanner import scan_pkg::*, dfa_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         load_state,
   input  logic         new_stream_id,
   input  flow_id_t     stream_id,
   input  byte_t        char_in,
   input  logic         char_in_vld,
   input  logic         eop,
   input  logic         enable,
   output match_count_t count,
   output logic         fired
);

   // Stage 1 to stage 2
   dfa_state_t ctx_state;
   logic       ctx_state_vld;
   byte_t      ctx_char;
   logic       ctx_char_vld;
   logic       ctx_eop;
   logic       ctx_enable;
   flow_id_t   ctx_flow;
   logic       ctx_start;

   // Stage 2 to stage 3
   dfa_state_t dfa_state;
   logic       dfa_accept;
   logic       dfa_eop;
   logic       dfa_enable;
   flow_id_t   dfa_flow;
   logic       dfa_start;

   // Write-back from stage 3 into the flow memory
   logic       save_vld;
   flow_id_t   save_flow;
   dfa_state_t save_state;

   stream_context u_stream_context (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .enable        (enable),
      .save_vld      (save_vld),
      .save_flow     (save_flow),
      .save_state    (save_state),
      .ctx_state     (ctx_state),
      .ctx_state_vld (ctx_state_vld),
      .ctx_char      (ctx_char),
      .ctx_char_vld  (ctx_char_vld),
      .ctx_eop       (ctx_eop),
      .ctx_enable    (ctx_enable),
      .ctx_flow      (ctx_flow),
      .ctx_start     (ctx_start)
   );

   regex_dfa u_regex_dfa (
      .clk           (clk),
      .rst_n         (rst_n),
      .ctx_state     (ctx_state),
      .ctx_state_vld (ctx_state_vld),
      .ctx_char      (ctx_char),
      .ctx_char_vld  (ctx_char_vld),
      .ctx_eop       (ctx_eop),
      .ctx_enable    (ctx_enable),
      .ctx_flow      (ctx_flow),
      .ctx_start     (ctx_start),
      .dfa_state     (dfa_state),
      .dfa_accept    (dfa_accept),
      .dfa_eop       (dfa_eop),
      .dfa_enable    (dfa_enable),
      .dfa_flow      (dfa_flow),
      .dfa_start     (dfa_start)
   );

   match_tally u_match_tally (
      .clk        (clk),
      .rst_n      (rst_n),
      .dfa_state  (dfa_state),
      .dfa_accept (dfa_accept),
      .dfa_eop    (dfa_eop),
      .dfa_enable (dfa_enable),
      .dfa_flow   (dfa_flow),
      .dfa_start  (dfa_start),
      .count      (count),
      .fired      (fired),
      .save_vld   (save_vld),
      .save_flow  (save_flow),
      .save_state (save_state)
   );

endmodule

`default_nettype wire

/* test/regex_scanner_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// Concurrent checks on the scanner top level
module regex_scanner_properties import scan_pkg::*; (
   input logic         clk,
   input logic         rst_n,
   input logic         load_state,
   input logic         eop,
   input logic         enable,
   input match_count_t count,
   input logic         fired,
   input logic         save_vld
);

   // Number of failed assertions
   int fail_count = 0;

   // Synchronous reset clears both outputs
   reset_clears: assert property (@(posedge clk) !rst_n |=> (count == '0) && !fired)
   else
   begin
      fail_count++;
      $error("count or fired not cleared by reset");
   end

   // Count moves only three cycles after an eop, by one and wrapping
   count_step: assert property (@(posedge clk) disable iff (!rst_n)
      (count != $past(count)) |->
         ($past(eop, 3) && (count == match_count_t'($past(count) + 1))))
   else
   begin
      fail_count++;
      $error("count changed without an eop three cycles earlier or by more than one");
   end

   // New packet clears the match level
   fired_clear: assert property (@(posedge clk) disable iff (!rst_n)
      $past(load_state, 3) |-> !fired)
   else
   begin
      fail_count++;
      $error("fired still high three cycles after load_state");
   end

   // Write-back only for enabled packets
   save_enabled: assert property (@(posedge clk) disable iff (!rst_n)
      save_vld |-> ($past(eop, 3) && $past(enable, 3)))
   else
   begin
      fail_count++;
      $error("state saved without an enabled eop three cycles earlier");
   end

endmodule

`default_nettype wire

/* test/regex_scanner_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_settings.svh"

// Testbench for the multi-flow signature scanner
module regex_scanner_tb import scan_pkg::*; ();

   localparam int CLK_PERIOD    = 8;
   // Input cycle to count and fired
   localparam int LATENCY       = 3;
   localparam int NUM_RANDOM    = 400;
   localparam int FIRED_TIMEOUT = 10;

   logic         clk;
   logic         rst_n;
   logic         load_state;
   logic         new_stream_id;
   flow_id_t     stream_id;
   byte_t        char_in;
   logic         char_in_vld;
   logic         eop;
   logic         enable;
   match_count_t count;
   logic         fired;

   // Signature indexed by the number of characters already matched
   byte_t    sig_text [4]    = '{"e", "v", "i", "l"};
   flow_id_t flow_pool [4]   = '{6'd0, 6'd1, 6'd2, 6'd63};
   byte_t    letter_pool [5] = '{"e", "v", "i", "l", "x"};

   // Reference model of the matched length per flow
   int           saved_len [`SCAN_NUM_FLOWS];
   bit           saved_ok  [`SCAN_NUM_FLOWS];
   int           cur_len;
   bit           pkt_flag;
   match_count_t model_count;
   logic [1:0]   gen_pos;

   // Expected outputs per input cycle with the oldest first
   match_count_t exp_count_q [$];
   bit           exp_fired_q [$];
   byte_t        pkt_bytes [$];

   int check_errors;
   int timeout_errors;
   int prop_errors;

   regex_scanner u_regex_scanner (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .enable        (enable),
      .count         (count),
      .fired         (fired)
   );

   bind regex_scanner regex_scanner_properties u_regex_scanner_properties (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .eop        (eop),
      .enable     (enable),
      .count      (count),
      .fired      (fired),
      .save_vld   (save_vld)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Length of the matched signature prefix after one more byte
   function automatic int next_len(input int len, input byte_t ch);
      if (ch == sig_text[0])
         return 1;
      if (len >= 1 && len <= 3 && ch == sig_text[len[1:0]])
         return len + 1;
      return 0;
   endfunction

   function automatic void load_text(input string text);
      pkt_bytes.delete();
      for (int i = 0; i < text.len(); i++)
         pkt_bytes.push_back(text[i]);
   endfunction

   // Random payload biased toward the signature letters in order
   task automatic load_random(input int len);
      logic [2:0] pick;
      pkt_bytes.delete();
      for (int i = 0; i < len; i++)
      begin
         pick = 3'($urandom_range(0, 4));
         if ($urandom_range(0, 2) != 0)
         begin
            pkt_bytes.push_back(sig_text[gen_pos]);
            gen_pos = gen_pos + 2'd1;
         end
         else
            pkt_bytes.push_back(letter_pool[pick]);
      end
   endtask

   // Drive one input cycle and update the model, then check outputs of three cycles ago
   task automatic step_cycle(input logic ld, input logic new_id, input flow_id_t sid,
                             input byte_t ch, input logic ch_vld,
                             input logic last, input logic en);
      match_count_t old_count;
      bit           old_fired;
      @(posedge clk);
      load_state    <= ld;
      new_stream_id <= new_id;
      stream_id     <= sid;
      char_in       <= ch;
      char_in_vld   <= ch_vld;
      eop           <= last;
      enable        <= en;
      if (ld)
      begin
         cur_len  = new_id ? 0 : saved_len[sid];
         pkt_flag = 1'b0;
      end
      if (ch_vld)
      begin
         cur_len = next_len(cur_len, ch);
         if (cur_len == 4)
            pkt_flag = 1'b1;
      end
      // Disabled packets keep the old saved state and drop the match
      if (last && en)
      begin
         saved_len[sid] = cur_len;
         saved_ok[sid]  = 1'b1;
         model_count    = model_count + match_count_t'(pkt_flag);
      end
      else if (last)
         pkt_flag = 1'b0;
      exp_count_q.push_back(model_count);
      exp_fired_q.push_back(pkt_flag);
      @(negedge clk);
      if (exp_count_q.size() > LATENCY)
      begin
         old_count = exp_count_q.pop_front();
         old_fired = exp_fired_q.pop_front();
         assert (count == old_count)
         else
         begin
            check_errors++;
            $display("CHECK FAILED %0t: count is %0d, expected %0d", $time, count, old_count);
         end
         assert (fired == old_fired)
         else
         begin
            check_errors++;
            $display("CHECK FAILED %0t: fired is %0b, expected %0b", $time, fired, old_fired);
         end
      end
   endtask

   task automatic idle_cycles(input flow_id_t sid, input int n);
      for (int i = 0; i < n; i++)
         step_cycle(1'b0, 1'b0, sid, 8'h00, 1'b0, 1'b0, 1'b0);
   endtask

   // Load cycle and bytes with gaps up to max_gap, then eop
   task automatic send_packet(input flow_id_t sid, input logic new_id, input logic en,
                              input int max_gap);
      int gap;
      step_cycle(1'b1, new_id, sid, 8'h00, 1'b0, 1'b0, 1'b0);
      foreach (pkt_bytes[i])
      begin
         gap = (max_gap > 0) ? int'($urandom_range(0, max_gap)) : 0;
         idle_cycles(sid, gap);
         step_cycle(1'b0, 1'b0, sid, pkt_bytes[i], 1'b1, 1'b0, 1'b0);
      end
      step_cycle(1'b0, 1'b0, sid, 8'h00, 1'b0, 1'b1, en);
   endtask

   task automatic wait_fired(input flow_id_t sid);
      int n;
      n = 0;
      while (!fired && n < FIRED_TIMEOUT)
      begin
         idle_cycles(sid, 1);
         n++;
      end
      if (!fired)
      begin
         timeout_errors++;
         $display("Timeout at %0t: fired did not rise within %0d cycles", $time, n);
      end
   endtask

   initial
   begin
      logic [1:0] pick;
      flow_id_t   flow;
      logic       new_id;
      logic       en;
      void'($urandom(14));
      rst_n         <= 1'b0;
      load_state    <= 1'b0;
      new_stream_id <= 1'b0;
      stream_id     <= '0;
      char_in       <= '0;
      char_in_vld   <= 1'b0;
      eop           <= 1'b0;
      enable        <= 1'b0;
      cur_len       = 0;
      pkt_flag      = 1'b0;
      model_count   = '0;
      gen_pos       = 2'd0;
      check_errors   = 0;
      timeout_errors = 0;
      foreach (saved_ok[f])
         saved_ok[f] = 1'b0;

      repeat (10)
         @(posedge clk);
      rst_n <= 1'b1;
      idle_cycles(6'd0, 8);

      // Each matching packet counts once even with two hits
      load_text("xxevilxx");
      send_packet(6'd1, 1'b1, 1'b1, 0);
      wait_fired(6'd1);
      load_text("evilxevil");
      send_packet(6'd1, 1'b1, 1'b1, 1);
      wait_fired(6'd1);

      // Disabled match and resume from the state before it
      load_text("xev");
      send_packet(6'd2, 1'b1, 1'b1, 0);
      load_text("xxevil");
      send_packet(6'd2, 1'b0, 1'b0, 0);
      idle_cycles(6'd2, 1);
      load_text("il");
      send_packet(6'd2, 1'b0, 1'b1, 0);
      wait_fired(6'd2);

      // Split match over every restore distance from gap 0 to 4
      for (int g = 0; g < 5; g++)
      begin
         load_text("xev");
         send_packet(6'd3, 1'b1, 1'b1, 0);
         idle_cycles(6'd3, g);
         load_text("il");
         send_packet(6'd3, 1'b0, 1'b1, 0);
         wait_fired(6'd3);
      end

      // New flow id discards the partial match
      load_text("ev");
      send_packet(6'd4, 1'b1, 1'b1, 0);
      load_text("il");
      send_packet(6'd4, 1'b1, 1'b1, 0);

      // Interleaved flows keep their own partial matches
      load_text("evi");
      send_packet(6'd1, 1'b1, 1'b1, 0);
      load_text("ev");
      send_packet(6'd2, 1'b1, 1'b1, 0);
      load_text("l");
      send_packet(6'd1, 1'b0, 1'b1, 0);
      wait_fired(6'd1);
      load_text("l");
      send_packet(6'd2, 1'b0, 1'b1, 0);

      for (int p = 0; p < NUM_RANDOM; p++)
      begin
         pick   = 2'($urandom_range(0, 3));
         flow   = flow_pool[pick];
         // Flows never saved must start fresh
         new_id = !saved_ok[flow] || ($urandom_range(0, 7) == 0);
         en     = ($urandom_range(0, 3) != 0);
         load_random(int'($urandom_range(0, 10)));
         send_packet(flow, new_id, en, 2);
         idle_cycles(flow, int'($urandom_range(0, 3)));
      end

      // Flush the pipeline so the last packets are checked
      idle_cycles(6'd0, LATENCY + 2);
      prop_errors = u_regex_scanner.u_regex_scanner_properties.fail_count;
      $display("Errors: check %0d, timeout %0d, assertion %0d, final count %0d",
               check_errors, timeout_errors, prop_errors, count);
      if (check_errors + timeout_errors + prop_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* regex_scanner.f */
+incdir+hw
hw/scan_pkg.sv
hw/dfa_pkg.sv
hw/stream_context.sv
hw/regex_dfa.sv
hw/match_tally.sv
hw/regex_scanner.sv
test/regex_scanner_properties.sv
test/regex_scanner_tb.sv

/* Makefile */
# Verilator build and run of the scanner testbench

TOP := regex_scanner_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f regex_scanner.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
